//--- motor_ctrl_pkg.sv
package motor_ctrl_pkg;

  // Camera centroid and proximity sensor widths
  localparam int CENT_W = 8;
  localparam int PROX_W = 3;

  // Wheel speed, signed two's complement
  localparam int VEL_W = 8;

  // Proportional term taken from the centroid
  localparam int P_W = 3;

  // Search counter width and the lost threshold
  localparam int CNT_W = 12;
  localparam logic [CNT_W-1:0] SEARCH_LIMIT = 12'd1000;

  // Steering gains
  // Proximity 3 is neutral, speed drops as the target gets closer
  localparam logic [PROX_W-1:0] PROX_CENTER = 3'd3;
  localparam logic [VEL_W-1:0]  PROX_GAIN   = 8'd16;
  localparam logic [VEL_W-1:0]  P_GAIN      = 8'd8;

  // SPI link timing, counted in clk cycles
  localparam int SCLK_HALF  = 2;
  localparam int FRAME_BITS = 16;
  localparam int GAP_CYCLES = 2;

  // Divider and bit counter widths
  localparam int DIV_W     = $clog2(2 * SCLK_HALF);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);

  // Divider values where sclk rises and falls, and the last gap cycle
  localparam logic [DIV_W-1:0]     DIV_RISE = DIV_W'(SCLK_HALF - 1);
  localparam logic [DIV_W-1:0]     DIV_FALL = DIV_W'(2 * SCLK_HALF - 1);
  localparam logic [DIV_W-1:0]     GAP_LAST = DIV_W'(GAP_CYCLES - 1);
  localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(FRAME_BITS - 1);

  // Target tracking state
  typedef enum logic [0:0] {
    TRACK_LOOKING,
    TRACK_LOST
  } track_state_e;

  // SPI transmitter state
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_GAP
  } spi_state_e;

endpackage

//--- motor_ctrl_sva.sv
`timescale 1ns/1ps

module motor_ctrl_sva (
  input logic                             clk,
  input logic                             rst,
  input motor_ctrl_pkg::spi_state_e       spi_state,
  input logic                             sclk,
  input logic                             mosi,
  input logic                             cs_n,
  input logic [motor_ctrl_pkg::CNT_W-1:0] search_cnt,
  input logic                             lost
);

  // Chip select only low while a frame shifts
  cs_idle_high: assert property (@(posedge clk) disable iff (rst)
    (spi_state != motor_ctrl_pkg::SPI_SHIFT) |-> cs_n)
    else $error("cs_n low outside SPI_SHIFT");

  // Mode 0 idle level
  sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
    cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  // Data held through the high half of sclk
  mosi_stable: assert property (@(posedge clk) disable iff (rst)
    (sclk && $past(sclk)) |-> $stable(mosi))
    else $error("mosi changed while sclk was high");

  // Lost only after the counter passed the limit
  lost_after_limit: assert property (@(posedge clk) disable iff (rst)
    $rose(lost) |-> ($past(search_cnt) > motor_ctrl_pkg::SEARCH_LIMIT))
    else $error("lost rose before the search limit");

endmodule

// SPI side, tracker inputs held quiet
bind motor_spi_tx motor_ctrl_sva u_spi_sva (
  .clk        (clk),
  .rst        (rst),
  .spi_state  (state),
  .sclk       (sclk),
  .mosi       (mosi),
  .cs_n       (cs_n),
  .search_cnt ('0),
  .lost       (1'b0)
);

// Tracker side, SPI inputs held in a legal shifting pattern
bind target_tracker motor_ctrl_sva u_tracker_sva (
  .clk        (clk),
  .rst        (rst),
  .spi_state  (motor_ctrl_pkg::SPI_SHIFT),
  .sclk       (1'b0),
  .mosi       (1'b0),
  .cs_n       (1'b0),
  .search_cnt (search_cnt),
  .lost       (lost)
);

//--- motor_ctrl_top.sv
`timescale 1ns/1ps

module motor_ctrl_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              enable,
  input  logic [motor_ctrl_pkg::CENT_W-1:0] centroid,
  input  logic                              new_centroid,
  input  logic [motor_ctrl_pkg::PROX_W-1:0] proximity,
  output logic [motor_ctrl_pkg::VEL_W-1:0]  v_left_motor,
  output logic [motor_ctrl_pkg::VEL_W-1:0]  v_right_motor,
  output logic                              lost,
  output logic                              spi_sclk,
  output logic                              spi_mosi,
  output logic                              spi_cs_n
);

  // Tracker to steering
  logic [motor_ctrl_pkg::CENT_W-1:0] last_centroid;

  // Target memory and search timeout
  target_tracker u_tracker (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .new_centroid  (new_centroid),
    .centroid      (centroid),
    .last_centroid (last_centroid),
    .lost          (lost)
  );

  // Wheel speeds, also fed straight to the SPI link
  steer_ctrl u_steer (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .lost          (lost),
    .proximity     (proximity),
    .last_centroid (last_centroid),
    .left_speed    (v_left_motor),
    .right_speed   (v_right_motor)
  );

  // Write-only link to the motor driver
  motor_spi_tx u_spi_tx (
    .clk         (clk),
    .rst         (rst),
    .left_speed  (v_left_motor),
    .right_speed (v_right_motor),
    .sclk        (spi_sclk),
    .mosi        (spi_mosi),
    .cs_n        (spi_cs_n)
  );

endmodule

//--- motor_spi_tx.sv
`timescale 1ns/1ps

module motor_spi_tx (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic signed [motor_ctrl_pkg::VEL_W-1:0] left_speed,
  input  logic signed [motor_ctrl_pkg::VEL_W-1:0] right_speed,
  output logic                                   sclk,
  output logic                                   mosi,
  output logic                                   cs_n
);

  motor_ctrl_pkg::spi_state_e            state;
  logic [motor_ctrl_pkg::DIV_W-1:0]      div_cnt;
  logic [motor_ctrl_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [motor_ctrl_pkg::FRAME_BITS-1:0] shift_reg;
  logic                                  load;
  logic                                  shift_en;

  // Latch a new frame after the idle cycle or at the end of the gap
  assign load = (state == motor_ctrl_pkg::SPI_IDLE) ||
                ((state == motor_ctrl_pkg::SPI_GAP) && (div_cnt == motor_ctrl_pkg::GAP_LAST));

  // Advance one bit as sclk falls, mode 0
  assign shift_en = (state == motor_ctrl_pkg::SPI_SHIFT) &&
                    (div_cnt == motor_ctrl_pkg::DIV_FALL);

  // MSB goes out first
  assign mosi = shift_reg[motor_ctrl_pkg::FRAME_BITS-1];

  // Frame data, left byte first
  always_ff @(posedge clk) begin
    if (load) begin
      shift_reg <= {left_speed, right_speed};
    end else if (shift_en) begin
      shift_reg <= {shift_reg[motor_ctrl_pkg::FRAME_BITS-2:0], 1'b0};
    end
  end

  // Frame FSM with clock divider and bit counter
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= motor_ctrl_pkg::SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
    end else begin
      case (state)
        motor_ctrl_pkg::SPI_IDLE: begin
          // One cycle after reset, then start streaming
          state   <= motor_ctrl_pkg::SPI_SHIFT;
          cs_n    <= 1'b0;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
        motor_ctrl_pkg::SPI_SHIFT: begin
          div_cnt <= div_cnt + 1'b1;
          // sclk low for the first half, high for the second
          if (div_cnt == motor_ctrl_pkg::DIV_RISE) begin
            sclk <= 1'b1;
          end
          if (shift_en) begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            if (bit_cnt == motor_ctrl_pkg::BIT_LAST) begin
              // Frame done, cs_n rise tells the driver to take it
              state <= motor_ctrl_pkg::SPI_GAP;
              cs_n  <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        motor_ctrl_pkg::SPI_GAP: begin
          div_cnt <= div_cnt + 1'b1;
          // Back to back frames, cs_n high for the gap only
          if (load) begin
            state   <= motor_ctrl_pkg::SPI_SHIFT;
            cs_n    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        default: begin
          state <= motor_ctrl_pkg::SPI_IDLE;
          sclk  <= 1'b0;
          cs_n  <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f src.f \
       --top-module tb_motor_ctrl -o sim_motor_ctrl \
  && ./obj_dir/sim_motor_ctrl | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }

//--- src.f
motor_ctrl_pkg.sv
target_tracker.sv
steer_ctrl.sv
motor_spi_tx.sv
motor_ctrl_top.sv
motor_ctrl_sva.sv
tb_motor_ctrl.sv

//--- steer_ctrl.sv
`timescale 1ns/1ps

module steer_ctrl (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    enable,
  input  logic                                    lost,
  input  logic        [motor_ctrl_pkg::PROX_W-1:0] proximity,
  input  logic        [motor_ctrl_pkg::CENT_W-1:0] last_centroid,
  output logic signed [motor_ctrl_pkg::VEL_W-1:0]  left_speed,
  output logic signed [motor_ctrl_pkg::VEL_W-1:0]  right_speed
);

  logic [motor_ctrl_pkg::P_W-1:0]   right_term;
  logic [motor_ctrl_pkg::P_W-1:0]   left_term;
  logic [motor_ctrl_pkg::VEL_W-1:0] right_base;
  logic [motor_ctrl_pkg::VEL_W-1:0] left_base;
  logic [motor_ctrl_pkg::VEL_W-1:0] prox_ext;
  logic [motor_ctrl_pkg::VEL_W-1:0] prox_corr;

  // Right term from the top bits of the centroid
  assign right_term = last_centroid[motor_ctrl_pkg::CENT_W-1 -: motor_ctrl_pkg::P_W];

  // Left term from the low bits with bit 0 as the MSB
  assign left_term = {last_centroid[0], last_centroid[1], last_centroid[2]};

  // Base speeds reach at most 7 * 8 and never overflow
  assign right_base = {{(motor_ctrl_pkg::VEL_W - motor_ctrl_pkg::P_W){1'b0}}, right_term}
                      * motor_ctrl_pkg::P_GAIN;
  assign left_base  = {{(motor_ctrl_pkg::VEL_W - motor_ctrl_pkg::P_W){1'b0}}, left_term}
                      * motor_ctrl_pkg::P_GAIN;

  // Zero-extend proximity to speed width
  assign prox_ext = {{(motor_ctrl_pkg::VEL_W - motor_ctrl_pkg::PROX_W){1'b0}}, proximity};

  // (prox - center) * -gain is computed as (center - prox) * gain
  // 8-bit arithmetic wraps exactly like the signed form
  // Values 48, 32, 16, 0, -16, -32, -48, -64 for proximity 0..7
  assign prox_corr = ({{(motor_ctrl_pkg::VEL_W - motor_ctrl_pkg::PROX_W){1'b0}},
                       motor_ctrl_pkg::PROX_CENTER} - prox_ext) * motor_ctrl_pkg::PROX_GAIN;

  // Registered speeds
  // Wheels are crossed so the left wheel follows the right term and vice versa
  always_ff @(posedge clk) begin
    if (rst) begin
      left_speed  <= '0;
      right_speed <= '0;
    end else if (!enable || lost) begin
      // Stop both wheels
      left_speed  <= '0;
      right_speed <= '0;
    end else begin
      left_speed  <= right_base + prox_corr;
      right_speed <= left_base + prox_corr;
    end
  end

endmodule

//--- target_tracker.sv
`timescale 1ns/1ps

module target_tracker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              enable,
  input  logic                              new_centroid,
  input  logic [motor_ctrl_pkg::CENT_W-1:0] centroid,
  output logic [motor_ctrl_pkg::CENT_W-1:0] last_centroid,
  output logic                              lost
);

  motor_ctrl_pkg::track_state_e     state;
  logic [motor_ctrl_pkg::CNT_W-1:0] search_cnt;
  logic                             valid_update;
  logic                             cnt_expired;

  // A zero centroid means nothing in view, so it is not a valid sighting
  assign valid_update = enable && new_centroid && (centroid != '0);

  // Counter has passed the search window
  assign cnt_expired = search_cnt > motor_ctrl_pkg::SEARCH_LIMIT;

  assign lost = (state == motor_ctrl_pkg::TRACK_LOST);

  // Last valid target position
  // Held through disable so steering resumes where it left off
  always_ff @(posedge clk) begin
    if (rst) begin
      last_centroid <= '0;
    end else if (valid_update) begin
      last_centroid <= centroid;
    end
  end

  // Cycles since the last valid sighting, saturating
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      search_cnt <= '0;
    end else if (valid_update) begin
      search_cnt <= '0;
    end else if (search_cnt != '1) begin
      search_cnt <= search_cnt + 1'b1;
    end
  end

  // Looking / lost FSM
  // Lost is entered one edge after the counter passes the limit
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      state <= motor_ctrl_pkg::TRACK_LOOKING;
    end else if (valid_update) begin
      state <= motor_ctrl_pkg::TRACK_LOOKING;
    end else if (cnt_expired) begin
      state <= motor_ctrl_pkg::TRACK_LOST;
    end
  end

endmodule

//--- tb_motor_ctrl.sv
`timescale 1ns/1ps

module tb_motor_ctrl;

  // One stimulus row, held for a number of cycles
  typedef struct {
    logic                              en;
    logic [motor_ctrl_pkg::CENT_W-1:0] cent;
    logic                              strobe;
    logic [motor_ctrl_pkg::PROX_W-1:0] prox;
    int                                hold;
  } row_t;

  logic                              clk;
  logic                              rst;
  logic                              enable;
  logic [motor_ctrl_pkg::CENT_W-1:0] centroid;
  logic                              new_centroid;
  logic [motor_ctrl_pkg::PROX_W-1:0] proximity;
  logic [motor_ctrl_pkg::VEL_W-1:0]  v_left_motor;
  logic [motor_ctrl_pkg::VEL_W-1:0]  v_right_motor;
  logic                              lost;
  logic                              spi_sclk;
  logic                              spi_mosi;
  logic                              spi_cs_n;

  row_t rows[$];
  int   total_hold;
  bit   table_ready;
  int   value_errors;
  int   other_errors;
  int   frames_checked;

  // Reference model of tracker and steering
  logic [7:0] m_last;
  int         m_cnt;
  logic       m_lost;
  logic [7:0] m_left;
  logic [7:0] m_right;

  // SPI frame decoder
  logic [15:0] rx_frame;
  int          rx_bits;
  logic [15:0] frame_exp;
  int          gap_cycles;
  bit          seen_frame;

  motor_ctrl_top DUT (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .centroid      (centroid),
    .new_centroid  (new_centroid),
    .proximity     (proximity),
    .v_left_motor  (v_left_motor),
    .v_right_motor (v_right_motor),
    .lost          (lost),
    .spi_sclk      (spi_sclk),
    .spi_mosi      (spi_mosi),
    .spi_cs_n      (spi_cs_n)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Wheel speed: 8 per term unit, minus 16 per proximity step above 3, wrapped
  function automatic logic [7:0] wheel_speed(input logic [2:0] term, input logic [2:0] prox);
    int v;
    v = 8 * int'(term) - 16 * (int'(prox) - 3);
    return v[7:0];
  endfunction

  task automatic add_row(input logic en, input logic [7:0] cent, input logic strobe,
                         input logic [2:0] prox, input int hold);
    row_t r;
    r.en     = en;
    r.cent   = cent;
    r.strobe = strobe;
    r.prox   = prox;
    r.hold   = hold;
    rows.push_back(r);
    total_hold += hold;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Model update on each edge, inputs are stable since 2 ns after the last edge
  always @(posedge clk) begin
    logic valid;
    logic lost_next;
    if (rst) begin
      m_last  = '0;
      m_cnt   = 0;
      m_lost  = 1'b0;
      m_left  = '0;
      m_right = '0;
    end else begin
      // Steering sees the tracker state from before this edge
      if (!enable || m_lost) begin
        m_left  = '0;
        m_right = '0;
      end else begin
        m_left  = wheel_speed(m_last[7:5], proximity);
        m_right = wheel_speed({m_last[0], m_last[1], m_last[2]}, proximity);
      end
      valid     = enable && new_centroid && (centroid != '0);
      lost_next = m_lost;
      if (!enable || valid) begin
        lost_next = 1'b0;
      end else if (m_cnt > int'(motor_ctrl_pkg::SEARCH_LIMIT)) begin
        lost_next = 1'b1;
      end
      if (valid) begin
        m_last = centroid;
      end
      if (!enable || valid) begin
        m_cnt = 0;
      end else if (m_cnt < (1 << motor_ctrl_pkg::CNT_W) - 1) begin
        m_cnt++;
      end
      m_lost = lost_next;
    end
  end

  // Outputs are compared mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      check_value("v_left_motor", v_left_motor, m_left);
      check_value("v_right_motor", v_right_motor, m_right);
      check_value("lost", lost, m_lost);
      // Speeds seen while cs_n is high are the ones the next frame latches
      if (spi_cs_n === 1'b1) begin
        frame_exp = {v_left_motor, v_right_motor};
        gap_cycles++;
      end
    end
  end

  always @(negedge spi_cs_n) begin
    if (!rst) begin
      if (seen_frame) begin
        check_value("spi_cs_n gap cycles", gap_cycles, 2);
      end
      rx_bits  = 0;
      rx_frame = '0;
    end
  end

  // Driver side: mosi taken on the rising sclk edge, MSB first
  always @(posedge spi_sclk) begin
    if (!rst && spi_cs_n === 1'b0) begin
      rx_frame = {rx_frame[14:0], spi_mosi};
      rx_bits++;
    end
  end

  always @(posedge spi_cs_n) begin
    if (!rst) begin
      if (rx_bits != 16) begin
        other_errors++;
        $display("SPI frame ended after %0d bits instead of 16 at %0t", rx_bits, $time);
      end
      check_value("spi frame", rx_frame, frame_exp);
      frames_checked++;
      seen_frame = 1'b1;
      gap_cycles = 0;
    end
  end

  initial begin
    int hold;
    int limit;
    logic [31:0] seed;
    row_t r;
    rst          = 1'b1;
    enable       = 1'b0;
    centroid     = '0;
    new_centroid = 1'b0;
    proximity    = '0;
    seed         = 32'h6981;

    // Proportional speeds and the wheel swap
    add_row(1'b1, 8'hE1, 1'b1, 3'd3, 1);
    add_row(1'b1, 8'h00, 1'b0, 3'd3, 4);
    // Proximity sweep on the kept centroid
    for (int p = 0; p < 8; p++) begin
      add_row(1'b1, 8'h00, 1'b0, 3'(p), 3);
    end
    // Zero centroid strobed, then a value without strobe
    add_row(1'b1, 8'h00, 1'b1, 3'd5, 2);
    add_row(1'b1, 8'h5A, 1'b0, 3'd5, 2);
    // Search timeout, then recovery
    limit = int'(motor_ctrl_pkg::SEARCH_LIMIT);
    add_row(1'b1, 8'h00, 1'b0, 3'd3, limit + 20);
    add_row(1'b1, 8'h47, 1'b1, 3'd2, 1);
    add_row(1'b1, 8'h00, 1'b0, 3'd2, 5);
    // Enable low ignores the strobe and restarts the counter
    add_row(1'b1, 8'h96, 1'b1, 3'd4, 1);
    add_row(1'b1, 8'h00, 1'b0, 3'd4, limit * 3 / 5);
    add_row(1'b0, 8'h33, 1'b1, 3'd4, 5);
    add_row(1'b1, 8'h00, 1'b0, 3'd4, limit * 3 / 5);
    // Random strobed targets
    for (int i = 0; i < 40; i++) begin
      seed = lcg_next(seed);
      hold = int'(seed[30:29]) + 1;
      add_row(1'b1, seed[23:16], 1'b1, seed[12:10], hold);
    end
    // Idle tail so the last frames complete
    add_row(1'b1, 8'h00, 1'b0, 3'd3, 200);
    table_ready = 1'b1;

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (rows[i]) begin
      r            = rows[i];
      enable       = r.en;
      centroid     = r.cent;
      new_centroid = r.strobe;
      proximity    = r.prox;
      repeat (r.hold) @(posedge clk);
      #2;
    end

    if (frames_checked == 0) begin
      other_errors++;
      $display("No complete SPI frame was received");
    end
    $display("Errors: %0d value mismatches, %0d other failures, %0d SPI frames checked",
             value_errors, other_errors, frames_checked);
    if (value_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    wait (table_ready);
    limit = total_hold + 2 * int'(motor_ctrl_pkg::SEARCH_LIMIT) + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule
